//--- compile.f
rtl/newton_pkg.sv
rtl/newton_if.sv
rtl/serial_mul.sv
rtl/serial_div.sv
rtl/newton_step.sv
rtl/newton_sqrt.sv
test/newton_sqrt_asserts.sv
test/newton_sqrt_tb.sv

//--- rtl/newton_if.sv
`default_nettype none

// one stage-to-stage link, valid/ready with guess and radicand
interface newton_if import newton_pkg::*; ();

	logic valid;
	logic ready;
	fix_t x;	// current guess
	fix_t a;	// radicand, passed along unchanged

	modport source (
		output valid,
		output x,
		output a,
		input  ready
	);

	modport sink (
		input  valid,
		input  x,
		input  a,
		output ready
	);

endinterface

`default_nettype wire

//--- rtl/newton_pkg.sv
`default_nettype none

package newton_pkg;

	// unsigned fixed point, 16 integer and 16 fraction bits
	localparam int WIDTH = 32;
	localparam int FRAC_BITS = 16;
	localparam int PROD_WIDTH = 2 * WIDTH;

	// wide enough for d << FRAC_BITS with any d
	localparam int DIV_WIDTH = 64;

	localparam int NUM_ITER = 4;	// chained iteration stages

	// one bit per cycle in both serial units
	localparam int MUL_CYCLES = WIDTH;
	localparam int DIV_CYCLES = DIV_WIDTH;
	localparam int MUL_CNT_W = $clog2(MUL_CYCLES);
	localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

	// upstream transfer to dn.valid with no stall:
	// start register, multiply (MUL_CYCLES+1), divide (DIV_CYCLES+1), result register
	localparam int STEP_CYCLES = MUL_CYCLES + DIV_CYCLES + 4;

	typedef logic [WIDTH-1:0] fix_t;
	typedef logic [PROD_WIDTH-1:0] prod_t;
	typedef logic [DIV_WIDTH-1:0] div_t;

endpackage

`default_nettype wire

//--- rtl/newton_sqrt.sv
`default_nettype none

module newton_sqrt import newton_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic in_valid,
	output logic      in_ready,
	input  wire fix_t in_a,
	input  wire fix_t in_x0,
	output logic      out_valid,
	input  wire logic out_ready,
	output fix_t      out_root
);

	// link i feeds stage i, the last one is the result side
	newton_if link [0:NUM_ITER] ();

	// input ports onto the first link
	assign link[0].valid = in_valid;
	assign link[0].x = in_x0;
	assign link[0].a = in_a;
	assign in_ready = link[0].ready;

	// each stage runs one iteration and holds one item,
	// so up to NUM_ITER radicands are in flight, in order
	generate
		for (genvar i = 0; i < NUM_ITER; i++) begin : g_stage
			newton_step i_step (
				.clk   (clk),
				.rst_n (rst_n),
				.up    (link[i]),
				.dn    (link[i+1])
			);
		end
	endgenerate

	// the radicand on the last link is not needed at the output
	assign out_valid = link[NUM_ITER].valid;
	assign out_root = link[NUM_ITER].x;
	assign link[NUM_ITER].ready = out_ready;

endmodule

`default_nettype wire

//--- rtl/newton_step.sv
`default_nettype none

module newton_step import newton_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	newton_if.sink   up,
	newton_if.source dn
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_SQUARE,
		S_DIVIDE,
		S_HOLD
	} state_t;

	state_t         state;
	logic           mul_start;
	logic           mul_done;
	prod_t          product;
	logic           div_start;
	logic           div_done;
	div_t           quotient;
	div_t           dividend;
	div_t           divisor;
	fix_t           x_q;
	fix_t           a_q;
	logic           ge_q;	// guess squared was at or above a
	prod_t          sq;
	prod_t          d;
	logic           sq_ge;
	fix_t           q;
	logic [WIDTH:0] sum;
	fix_t           x_new;

	// one item per stage, ready only while empty
	assign up.ready = (state == S_IDLE);
	assign dn.valid = (state == S_HOLD);
	assign dn.x = x_q;
	assign dn.a = a_q;

	serial_mul i_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (mul_start),
		.a       (x_q),
		.b       (x_q),
		.product (product),
		.done    (mul_done)
	);

	// x*x carries 2*FRAC_BITS fraction bits
	assign sq = product >> FRAC_BITS;
	assign sq_ge = (sq >= prod_t'(a_q));
	assign d = sq_ge ? (sq - prod_t'(a_q)) : (prod_t'(a_q) - sq);

	// d stays below 2^48, so the shift loses nothing
	assign dividend = div_t'(d << FRAC_BITS);
	assign divisor = div_t'(x_q) << 1;	// 2x
	assign div_start = (state == S_SQUARE) && mul_done;	// divider starts on the product

	serial_div i_div (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (div_start),
		.dividend (dividend),
		.divisor  (divisor),
		.quotient (quotient),
		.done     (div_done)
	);

	assign q = quotient[WIDTH-1:0];
	assign sum = {1'b0, x_q} + {1'b0, q};

	// correction, saturating at both ends of the range
	always_comb begin
		if (ge_q) begin
			x_new = (q > x_q) ? '0 : (x_q - q);
		end else begin
			x_new = sum[WIDTH] ? '1 : sum[WIDTH-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			mul_start <= 1'b0;
		end else begin
			mul_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (up.valid) begin
						state <= S_SQUARE;
						mul_start <= 1'b1;
					end
				end
				S_SQUARE: begin
					if (mul_done) begin
						state <= S_DIVIDE;
					end
				end
				S_DIVIDE: begin
					if (div_done) begin
						state <= S_HOLD;
					end
				end
				S_HOLD: begin
					if (dn.ready) begin	// taken downstream
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (up.valid && up.ready) begin
			x_q <= up.x;
			a_q <= up.a;
		end else if ((state == S_DIVIDE) && div_done) begin
			x_q <= x_new;	// new guess replaces the old one
		end
		if (div_start) begin
			ge_q <= sq_ge;
		end
	end

endmodule

`default_nettype wire

//--- rtl/serial_div.sv
`default_nettype none

module serial_div import newton_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic start,
	input  wire div_t dividend,
	input  wire div_t divisor,
	output div_t      quotient,
	output logic      done
);

	logic                 busy;
	logic [DIV_CNT_W-1:0] cnt;
	logic                 div_zero;
	div_t                 rem;	// partial remainder, always below the divisor
	div_t                 quo;	// dividend bits shift out, quotient bits shift in
	div_t                 dsr;
	logic [DIV_WIDTH:0]   shifted;
	logic [DIV_WIDTH:0]   trial;
	logic                 fits;

	// next dividend bit into the remainder, then try the subtraction
	assign shifted = {rem, quo[DIV_WIDTH-1]};
	assign fits = (shifted >= {1'b0, dsr});
	assign trial = shifted - {1'b0, dsr};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			div_zero <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= DIV_CNT_W'(DIV_CYCLES - 1);
				div_zero <= (divisor == '0);
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem <= '0;
			quo <= dividend;
			dsr <= divisor;
		end else if (busy) begin
			// restoring step, keep the shifted value when the divisor does not fit
			if (fits) begin
				rem <= trial[DIV_WIDTH-1:0];
			end else begin
				rem <= shifted[DIV_WIDTH-1:0];
			end
			quo <= {quo[DIV_WIDTH-2:0], fits};
		end
	end

	// a zero divisor would leave all ones in quo
	assign quotient = div_zero ? '0 : quo;

endmodule

`default_nettype wire

//--- rtl/serial_mul.sv
`default_nettype none

module serial_mul import newton_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic start,
	input  wire fix_t a,
	input  wire fix_t b,
	output prod_t     product,
	output logic      done
);

	logic                 busy;
	logic [MUL_CNT_W-1:0] cnt;
	prod_t                mcand;	// multiplicand, shifted left each cycle
	fix_t                 mplier;	// multiplier, shifted right each cycle
	prod_t                acc;

	// bit counter, done pulses in the cycle after the last bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= MUL_CNT_W'(MUL_CYCLES - 1);
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= prod_t'(a);
			mplier <= b;
			acc <= '0;
		end else if (busy) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign product = acc;	// held until the next start

endmodule

`default_nettype wire

//--- test/newton_sqrt_asserts.sv
`default_nettype none

module newton_sqrt_asserts import newton_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire logic in_ready,
	input wire logic out_valid,
	input wire logic out_ready,
	input wire fix_t out_root
);

	int fail_count = 0;	// read by the testbench

	// a stalled result stays on the port unchanged
	a_out_held: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_root))
	else begin
		$error("out_valid dropped or out_root changed while stalled");
		fail_count++;
	end

	// the first stage holds one item, so it is busy right after taking one
	a_in_one_item: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && in_ready |=> !in_ready)
	else begin
		$error("in_ready stayed high right after an input was taken");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> !out_valid)
	else begin
		$error("out_valid high during or right after reset");
		fail_count++;
	end

	a_root_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(out_root))
	else begin
		$error("out_root unknown while out_valid is high");
		fail_count++;
	end

endmodule

bind newton_sqrt newton_sqrt_asserts i_asserts (.*);

`default_nettype wire

//--- test/newton_sqrt_tb.sv
`default_nettype none

module newton_sqrt_tb import newton_pkg::*; ();

	localparam int DRIVE_DLY = 5;
	localparam logic [31:0] SEED = 32'd19451;
	localparam int N_KNOWN = 4;
	localparam int N_RAND = 24;
	localparam int N_STALL = 24;
	localparam int N_HIGH = 3;
	localparam int N_ZERO = 3;
	localparam int NUM_TESTS = N_KNOWN + N_RAND + N_STALL + N_HIGH + N_ZERO;
	localparam int TIMEOUT_CYCLES = (NUM_TESTS + NUM_ITER) * NUM_ITER * STEP_CYCLES * 2;
	localparam fix_t ONE = 32'h0001_0000;	// 1.0 in the 16.16 format

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	fix_t in_a;
	fix_t in_x0;
	logic out_valid;
	logic out_ready;
	fix_t out_root;

	fix_t        expected_q[$];
	fix_t        exp_root;
	int          sent = 0;
	int          received = 0;
	int          cycles = 0;
	logic        stall_mode = 1'b0;
	logic [31:0] rng_data;
	logic [31:0] rng_ready = ~SEED;	// separate stream for out_ready

	newton_sqrt i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_a      (in_a),
		.in_x0     (in_x0),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_root  (out_root)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] r;
		r = s;
		r = r ^ (r << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	// NUM_ITER Newton steps in wide arithmetic, saturating to the 32-bit range
	function automatic fix_t ref_root(input fix_t a, input fix_t x0);
		logic [63:0] x;
		logic [63:0] sq;
		logic [63:0] d;
		logic [63:0] q;
		logic [63:0] t;
		x = 64'(x0);
		for (int i = 0; i < NUM_ITER; i++) begin
			sq = (x * x) >> FRAC_BITS;
			d = (sq >= 64'(a)) ? sq - 64'(a) : 64'(a) - sq;
			q = (x == 0) ? 64'd0 : 64'(32'((d << FRAC_BITS) / (x << 1)));
			if (sq >= 64'(a)) begin
				x = (q > x) ? 64'd0 : x - q;
			end else begin
				t = x + q;
				x = (t > 64'h0000_0000_FFFF_FFFF) ? 64'h0000_0000_FFFF_FFFF : t;
			end
		end
		return fix_t'(x);
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input fix_t got, input fix_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// offer one item and hold it until the DUT takes it
	task automatic send_item(input fix_t a, input fix_t x0);
		logic taken;
		in_valid = 1'b1;
		in_a = a;
		in_x0 = x0;
		taken = 1'b0;
		while (!taken) begin
			taken = in_ready;	// stable between edges
			@(posedge clk);
			#DRIVE_DLY;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_random(input int count);
		fix_t a;
		fix_t x0;
		for (int i = 0; i < count; i++) begin
			rng_data = xorshift(rng_data);
			a = rng_data;
			rng_data = xorshift(rng_data);
			x0 = (rng_data == '0) ? 32'd1 : rng_data;
			send_item(a, x0);
		end
	endtask

	task automatic wait_drain();
		while (received != sent) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
	endtask

	// out_ready random under stall_mode, otherwise always high
	always @(posedge clk) begin
		#DRIVE_DLY;
		if (stall_mode) begin
			rng_ready = xorshift(rng_ready);
			out_ready = rng_ready[7];
		end else begin
			out_ready = 1'b1;
		end
	end

	// inputs and outputs sampled mid-cycle, where they are stable
	always @(negedge clk) begin
		if (rst_n && in_valid && in_ready) begin
			expected_q.push_back(ref_root(in_a, in_x0));
			sent++;
		end
		if (rst_n && out_valid && out_ready) begin
			if (expected_q.size() == 0) begin
				stop_with_error("a result came out with no input waiting for it");
			end else begin
				exp_root = expected_q.pop_front();
				check_value("out_root", out_root, exp_root);
				received++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_with_error($sformatf("timeout after %0d cycles, %0d of %0d results received",
				cycles, received, NUM_TESTS));
		end else if (i_dut.i_asserts.fail_count != 0) begin
			stop_with_error("a handshake assertion failed");
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_a = '0;
		in_x0 = '0;
		out_ready = 1'b0;
		rng_data = SEED;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;

		// the reference itself lands near the true roots
		check_value("ref_root of 4.0", ref_root(32'h0004_0000, ONE) >> 8, 32'h200);
		check_value("ref_root of 9.0", ref_root(32'h0009_0000, ONE) >> 8, 32'h300);

		send_item(32'h0004_0000, ONE);
		send_item(32'h0002_0000, ONE);
		send_item(32'h0009_0000, ONE);
		send_item(32'h0000_4000, ONE);	// 0.25
		wait_drain();

		send_random(N_RAND);
		wait_drain();

		stall_mode = 1'b1;
		send_random(N_STALL);
		wait_drain();
		stall_mode = 1'b0;

		// guesses far above the root, then a small x whose first correction overflows
		send_item(32'h0002_0000, 32'h00C8_0000);
		send_item(ONE, 32'hFFFF_FFFF);
		send_item(32'h01FD_FFFF, 32'h0000_00FF);
		wait_drain();

		for (int i = 0; i < N_ZERO; i++) begin
			rng_data = xorshift(rng_data);
			check_value("ref_root with zero guess", ref_root(rng_data, '0), '0);
			send_item(rng_data, '0);
		end
		wait_drain();

		if (received == NUM_TESTS && expected_q.size() == 0 &&
			i_dut.i_asserts.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			stop_with_error($sformatf("%0d results received, %0d expected, %0d assertion failures",
				received, NUM_TESTS, i_dut.i_asserts.fail_count));
		end
	end

endmodule

`default_nettype wire
